// ==== mem_arbiter.sv ====
/* Round-robin arbiter for RAM port A
   Grants one queue per cycle after init and routes read data back by a tag pipe */
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                        clk,
  input  logic                        rsta,
  input  logic                        i_init_done,
  // Queue heads
  input  logic                        i_req0_valid,
  input  mem_pkg::op_e                i_req0_op,
  input  logic [mem_pkg::ADDR_W-1:0] i_req0_addr,
  input  logic [mem_pkg::DATA_W-1:0] i_req0_wdata,
  input  logic                        i_req1_valid,
  input  mem_pkg::op_e                i_req1_op,
  input  logic [mem_pkg::ADDR_W-1:0] i_req1_addr,
  input  logic [mem_pkg::DATA_W-1:0] i_req1_wdata,
  output logic                        o_grant0,
  output logic                        o_grant1,
  // RAM port A
  output logic                        o_en_a,
  output logic                        o_we_a,
  output logic [mem_pkg::ADDR_W-1:0] o_addr_a,
  output logic [mem_pkg::DATA_W-1:0] o_din_a,
  input  logic [mem_pkg::DATA_W-1:0] i_dout_a,
  // Read responses
  output logic                        o_rvalid0,
  output logic [mem_pkg::DATA_W-1:0] o_rdata0,
  output logic                        o_rvalid1,
  output logic [mem_pkg::DATA_W-1:0] o_rdata1
);

  import mem_pkg::*;

  logic              prio;      // Favored side, 0 or 1
  op_e               sel_op;
  logic              rd_issue;  // Granted read this cycle
  logic [RD_LAT-1:0] tag_v;     // Read in flight per stage
  logic [RD_LAT-1:0] tag_id;    // Owning client per stage

  // Grant logic, nothing before clear completes
  always_comb
  begin
    o_grant0 = 1'b0;
    o_grant1 = 1'b0;
    if (i_init_done)
    begin
      if (i_req0_valid && i_req1_valid)
      begin
        o_grant0 = !prio;  // Contention, favored side wins
        o_grant1 = prio;
      end
      else
      begin
        o_grant0 = i_req0_valid;
        o_grant1 = i_req1_valid;
      end
    end
  end

  // Port A from granted head
  assign sel_op   = o_grant1 ? i_req1_op : i_req0_op;
  assign o_en_a   = o_grant0 || o_grant1;
  assign o_we_a   = o_en_a && (sel_op == OP_WRITE);
  assign o_addr_a = o_grant1 ? i_req1_addr : i_req0_addr;
  assign o_din_a  = o_grant1 ? i_req1_wdata : i_req0_wdata;
  assign rd_issue = o_en_a && (sel_op == OP_READ);

  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      prio  <= 1'b0;
      tag_v <= '0;
    end
    else
    begin
      if (o_en_a)
      begin
        prio <= o_grant0;  // Other side favored next
      end
      tag_v <= {tag_v[RD_LAT-2:0], rd_issue};
    end
  end

  // Client id rides along, no reset needed beside tag_v
  always_ff @(posedge clk)
  begin
    tag_id <= {tag_id[RD_LAT-2:0], o_grant1};
  end

  // Last stage lines up with RAM output, RD_LAT after grant
  assign o_rvalid0 = tag_v[RD_LAT-1] && !tag_id[RD_LAT-1];
  assign o_rvalid1 = tag_v[RD_LAT-1] && tag_id[RD_LAT-1];
  assign o_rdata0  = i_dout_a;
  assign o_rdata1  = i_dout_a;

  a_one_grant : assert property (
    @(posedge clk) disable iff (rsta)
    !(o_grant0 && o_grant1)
  )
  else $error("mem_arbiter: both queues granted");

endmodule

// ==== mem_clear.sv ====
/* Post-reset clear sequencer
   Sweeps every RAM word once with zero data, then holds init done high */
`timescale 1ns/10ps

module mem_clear (
  input  logic                        clk,
  input  logic                        rsta,
  output logic                        o_en,
  output logic                        o_we,
  output logic [mem_pkg::ADDR_W-1:0] o_addr,
  output logic [mem_pkg::DATA_W-1:0] o_din,
  output logic                        o_init_done
);

  import mem_pkg::*;

  clear_state_e              state;
  logic [ADDR_W-1:0]         addr;  // Sweep address

  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      state <= CLR_SWEEP;
      addr  <= '0;
    end
    else if (state == CLR_SWEEP)
    begin
      addr <= addr + 1'b1;
      if (addr == ADDR_W'(RAM_DEPTH - 1))  // Last word written this cycle
      begin
        state <= CLR_DONE;
      end
    end
  end

  // Port B write every sweep cycle
  assign o_en        = (state == CLR_SWEEP);
  assign o_we        = o_en;
  assign o_addr      = addr;
  assign o_din       = '0;  // Clear value
  assign o_init_done = (state == CLR_DONE);

endmodule

// ==== mem_pkg.sv ====
/* Shared buffer memory definitions
   RAM geometry, read latency, credit depth and the op and clear state types */
package mem_pkg;

  // RAM geometry
  localparam int DATA_W    = 18;             // Word width
  localparam int ADDR_W    = 10;             // Word address width
  localparam int RAM_DEPTH = 1 << ADDR_W;    // 1024 words

  // Output pipeline of the RAM
  localparam int NBPIPE = 3;                 // Data pipe stages after the array read
  localparam int RD_LAT = NBPIPE + 2;        // Grant to data valid, array reg + out reg

  // Per-client flow control
  localparam int CREDITS = 4;                // Queue depth and initial credits
  localparam int QPTR_W  = $clog2(CREDITS);  // Queue pointer width
  localparam int QCNT_W  = $clog2(CREDITS + 1); // Occupancy, counts up to CREDITS

  // Request opcode, one bit on the wire
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Post-reset clear sequencer
  typedef enum logic
  {
    CLR_SWEEP = 1'b0,  // Zeroing words
    CLR_DONE  = 1'b1   // Sweep finished, idle for good
  } clear_state_e;

endpackage

// ==== mem_subsys_top.sv ====
/* Shared buffer memory subsystem
   Two credit-based clients share RAM port A, port B clears the RAM after reset */
`timescale 1ns/10ps

module mem_subsys_top (
  input  logic                        clk,
  input  logic                        rsta,
  // Client 0
  input  logic                        i_c0_valid,
  input  mem_pkg::op_e                i_c0_op,
  input  logic [mem_pkg::ADDR_W-1:0] i_c0_addr,
  input  logic [mem_pkg::DATA_W-1:0] i_c0_wdata,
  output logic                        o_c0_credit,
  output logic                        o_c0_rvalid,
  output logic [mem_pkg::DATA_W-1:0] o_c0_rdata,
  // Client 1
  input  logic                        i_c1_valid,
  input  mem_pkg::op_e                i_c1_op,
  input  logic [mem_pkg::ADDR_W-1:0] i_c1_addr,
  input  logic [mem_pkg::DATA_W-1:0] i_c1_wdata,
  output logic                        o_c1_credit,
  output logic                        o_c1_rvalid,
  output logic [mem_pkg::DATA_W-1:0] o_c1_rdata,
  output logic                        o_init_done
);

  import mem_pkg::*;

  // Queue heads and grants
  logic              req0_valid, req1_valid;
  op_e               req0_op, req1_op;
  logic [ADDR_W-1:0] req0_addr, req1_addr;
  logic [DATA_W-1:0] req0_wdata, req1_wdata;
  logic              grant0, grant1;
  // RAM port A
  logic              en_a, we_a;
  logic [ADDR_W-1:0] addr_a;
  logic [DATA_W-1:0] din_a, dout_a;
  // RAM port B, clear only
  logic              clr_en, clr_we;
  logic [ADDR_W-1:0] clr_addr;
  logic [DATA_W-1:0] clr_din;

  req_port u_req0 (
    .clk(clk), .rsta(rsta),
    .i_valid(i_c0_valid), .i_op(i_c0_op), .i_addr(i_c0_addr), .i_wdata(i_c0_wdata),
    .i_grant(grant0), .o_req_valid(req0_valid), .o_req_op(req0_op),
    .o_req_addr(req0_addr), .o_req_wdata(req0_wdata), .o_credit(o_c0_credit)
  );

  req_port u_req1 (
    .clk(clk), .rsta(rsta),
    .i_valid(i_c1_valid), .i_op(i_c1_op), .i_addr(i_c1_addr), .i_wdata(i_c1_wdata),
    .i_grant(grant1), .o_req_valid(req1_valid), .o_req_op(req1_op),
    .o_req_addr(req1_addr), .o_req_wdata(req1_wdata), .o_credit(o_c1_credit)
  );

  mem_arbiter u_arb (
    .clk(clk), .rsta(rsta), .i_init_done(o_init_done),
    .i_req0_valid(req0_valid), .i_req0_op(req0_op),
    .i_req0_addr(req0_addr), .i_req0_wdata(req0_wdata),
    .i_req1_valid(req1_valid), .i_req1_op(req1_op),
    .i_req1_addr(req1_addr), .i_req1_wdata(req1_wdata),
    .o_grant0(grant0), .o_grant1(grant1),
    .o_en_a(en_a), .o_we_a(we_a), .o_addr_a(addr_a), .o_din_a(din_a), .i_dout_a(dout_a),
    .o_rvalid0(o_c0_rvalid), .o_rdata0(o_c0_rdata),
    .o_rvalid1(o_c1_rvalid), .o_rdata1(o_c1_rdata)
  );

  mem_clear u_clear (
    .clk(clk), .rsta(rsta),
    .o_en(clr_en), .o_we(clr_we), .o_addr(clr_addr), .o_din(clr_din),
    .o_init_done(o_init_done)
  );

  uram_tdp #(
    .AWIDTH(ADDR_W),
    .DWIDTH(DATA_W),
    .PIPE  (NBPIPE)
  ) u_ram (
    .clk(clk), .rsta(rsta),
    .i_en_a(en_a), .i_we_a(we_a), .i_addr_a(addr_a), .i_din_a(din_a), .o_dout_a(dout_a),
    .i_en_b(clr_en), .i_we_b(clr_we), .i_addr_b(clr_addr), .i_din_b(clr_din)
  );

endmodule

// ==== mem_tests.txt ====
// test op client addr wdata expected, all hex; op 0 read, 1 write, 2 wait until idle
// test 1 reads go out during the clear and fill both queues; test 0 ends the list
1 0 0 000 00000 00000
1 0 0 3ff 00000 00000
1 0 0 155 00000 00000
1 0 0 2aa 00000 00000
1 0 1 001 00000 00000
1 0 1 200 00000 00000
1 0 1 0ff 00000 00000
1 0 1 37e 00000 00000
2 1 0 010 12345 00000
2 0 0 010 00000 12345
2 1 1 020 3abcd 00000
2 0 1 020 00000 3abcd
3 1 0 011 2f00f 00000
3 0 0 020 00000 3abcd
3 0 0 011 00000 2f00f
3 0 0 010 00000 12345
3 0 0 3ff 00000 00000
4 1 0 040 0a0a0 00000
4 1 1 050 15151 00000
4 0 0 040 00000 0a0a0
4 0 1 050 00000 15151
5 1 0 060 1d1d1 00000
5 2 0 000 00000 00000
5 0 1 060 00000 1d1d1
5 0 0 050 00000 15151
5 0 1 040 00000 0a0a0
0 0 0 000 00000 00000

// ==== req_port.sv ====
/* Per-client request queue with credit return
   CREDITS deep circular buffer, one credit pulse the cycle after each pop */
`timescale 1ns/10ps

module req_port (
  input  logic                        clk,
  input  logic                        rsta,
  // Client side
  input  logic                        i_valid,
  input  mem_pkg::op_e                i_op,
  input  logic [mem_pkg::ADDR_W-1:0] i_addr,
  input  logic [mem_pkg::DATA_W-1:0] i_wdata,
  output logic                        o_credit,
  // Arbiter side
  input  logic                        i_grant,
  output logic                        o_req_valid,
  output mem_pkg::op_e                o_req_op,
  output logic [mem_pkg::ADDR_W-1:0] o_req_addr,
  output logic [mem_pkg::DATA_W-1:0] o_req_wdata
);

  import mem_pkg::*;

  op_e               q_op    [CREDITS];  // Entry payload
  logic [ADDR_W-1:0] q_addr  [CREDITS];
  logic [DATA_W-1:0] q_wdata [CREDITS];

  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] count;   // Entries held
  logic              push;
  logic              pop;
  logic              full;

  // Wrap at CREDITS, also for a depth that is no power of two
  function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] ptr);
    return (ptr == QPTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = i_valid;
  assign pop  = i_grant && o_req_valid;  // Grant pops head same cycle
  assign full = (count == QCNT_W'(CREDITS));

  // Head of queue to arbiter
  assign o_req_valid = (count != '0);
  assign o_req_op    = q_op[rd_ptr];
  assign o_req_addr  = q_addr[rd_ptr];
  assign o_req_wdata = q_wdata[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end
    else
    begin
      o_credit <= pop;  // Credit back one cycle after pop
      if (push)
      begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop)
      begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Idle or push and pop together
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      q_op[wr_ptr]    <= i_op;
      q_addr[wr_ptr]  <= i_addr;
      q_wdata[wr_ptr] <= i_wdata;
    end
  end

  // Full queue means the client had no credit left
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (rsta)
    i_valid |-> !full
  )
  else $error("req_port: request sent with zero credits");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1
out=$( { verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
  -f sim.f -o tb_sim && ./obj_dir/tb_sim; } 2>&1 ) || { echo "$out"; echo "Build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qxF '*** PASSED ***' && exit 0 || exit 1

// ==== sim.f ====
mem_pkg.sv
uram_tdp.sv
mem_clear.sv
req_port.sv
mem_arbiter.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== tb_mem_subsys.sv ====
/* Shared buffer memory testbench
   Runs the steps of the test data file, checks read data, credit returns and clear timing */
`timescale 1ns/10ps

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int MAX_STEPS = 64;  // Lines the data array can hold

  logic              clk = 1'b0;
  logic              rsta;
  logic              valid [2];      // Per-client request inputs
  op_e               req_op [2];
  logic [ADDR_W-1:0] addr [2];
  logic [DATA_W-1:0] wdata [2];
  logic              credit [2];     // Per-client outputs
  logic              rvalid [2];
  logic [DATA_W-1:0] rdata [2];
  logic              init_done;

  logic [31:0]       steps [0:6*MAX_STEPS-1];  // Six columns per line
  int                n_steps;
  logic              loaded = 1'b0;
  int                sent [2] = '{0, 0};
  int                returned [2] = '{0, 0};
  logic [DATA_W-1:0] exp_q0 [$];     // Expected read data, client 0
  logic [DATA_W-1:0] exp_q1 [$];
  int                cur_test = 0;
  int                test_errs = 0;
  int                total_errs = 0;
  int                tests_run = 0;
  int                init_cycles = 0;
  logic              init_seen = 1'b0;
  logic [15:0]       lfsr;

  always #50 clk = ~clk;  // 100 ns period

  mem_subsys_top u_mem_subsys_top (
    .clk(clk), .rsta(rsta),
    .i_c0_valid(valid[0]), .i_c0_op(req_op[0]), .i_c0_addr(addr[0]), .i_c0_wdata(wdata[0]),
    .o_c0_credit(credit[0]), .o_c0_rvalid(rvalid[0]), .o_c0_rdata(rdata[0]),
    .i_c1_valid(valid[1]), .i_c1_op(req_op[1]), .i_c1_addr(addr[1]), .i_c1_wdata(wdata[1]),
    .o_c1_credit(credit[1]), .o_c1_rvalid(rvalid[1]), .o_c1_rdata(rdata[1]),
    .o_init_done(init_done)
  );

  function automatic string test_name(input int t);
    case (t)
      1:       return "clear";
      2:       return "write_read";
      3:       return "ordering";
      4:       return "credits";
      5:       return "sharing";
      default: return "unknown";
    endcase
  endfunction

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int credits_held(input int c);
    return CREDITS - sent[c] + returned[c];
  endfunction

  task automatic fail_value(input string what, input int exp_v, input int act_v);
    $display("[FAIL] %s: %s expected %0h actual %0h", test_name(cur_test), what, exp_v, act_v);
    test_errs++;
    total_errs++;
  endtask

  task automatic fail_msg(input string msg);
    $display("Error in test %s: %s", test_name(cur_test), msg);
    test_errs++;
    total_errs++;
  endtask

  // Zero to three idle cycles, one LFSR step per bit
  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      gap = (gap << 1) | int'(lfsr[0]);
    end
    repeat (gap) @(posedge clk);
  endtask

  // One request, held back while the client has no credit
  task automatic send_req(input int c, input int op, input int a, input int wd, input int ed);
    while (credits_held(c) == 0)
    begin
      @(posedge clk);
    end
    valid[c]  <= 1'b1;
    req_op[c] <= (op == 1) ? OP_WRITE : OP_READ;
    addr[c]   <= ADDR_W'(a);
    wdata[c]  <= DATA_W'(wd);
    sent[c]++;  // Credit spent
    if (op == 0)
    begin
      if (c == 0) exp_q0.push_back(DATA_W'(ed));
      else exp_q1.push_back(DATA_W'(ed));
    end
    @(posedge clk);
    valid[c] <= 1'b0;
  endtask

  // All credits home and no read outstanding, then one more cycle
  task automatic drain();
    while (credits_held(0) != CREDITS || credits_held(1) != CREDITS ||
           exp_q0.size() != 0 || exp_q1.size() != 0)
    begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic finish_test();
    drain();
    if (cur_test == 1 && init_done !== 1'b1)
    begin
      fail_msg("init done is not high after the clear");
    end
    $display("Test %0d %s: %s, %0d errors", cur_test, test_name(cur_test),
             (test_errs == 0) ? "ok" : "bad", test_errs);
    tests_run++;
    test_errs = 0;
  endtask

  task automatic check_read(input int c);
    logic [DATA_W-1:0] exp_d;
    if ((c == 0 && exp_q0.size() == 0) || (c == 1 && exp_q1.size() == 0))
    begin
      fail_msg($sformatf("client %0d got read data with no read outstanding", c));
    end
    else
    begin
      exp_d = (c == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      if (rdata[c] !== exp_d)
      begin
        fail_value($sformatf("client %0d read data", c), exp_d, rdata[c]);
      end
    end
  endtask

  // Outputs sampled mid-cycle, away from the rising edge
  always @(negedge clk)
  begin
    if (!rsta)
    begin
      if (!init_done) init_cycles++;  // Clear length
      else if (!init_seen)
      begin
        init_seen = 1'b1;
        if (init_cycles != RAM_DEPTH) fail_value("cycles to init done", RAM_DEPTH, init_cycles);
      end
      for (int c = 0; c < 2; c++)
      begin
        if (credit[c])
        begin
          returned[c]++;
          if (!init_done) fail_msg($sformatf("client %0d credit before init done", c));
        end
        if (credits_held(c) > CREDITS)
        begin
          fail_msg($sformatf("client %0d holds more than %0d credits", c, CREDITS));
        end
        if (rvalid[c]) check_read(c);
      end
    end
  end

  initial
  begin
    rsta = 1'b1;
    for (int c = 0; c < 2; c++)
    begin
      valid[c]  = 1'b0;
      req_op[c] = OP_READ;
      addr[c]   = '0;
      wdata[c]  = '0;
    end
    lfsr = 16'd63120;
    for (int i = 0; i < 6 * MAX_STEPS; i++) steps[i] = '0;
    $readmemh("mem_tests.txt", steps);
    n_steps = 0;
    while (n_steps < MAX_STEPS && steps[6*n_steps] != 0) n_steps++;  // Test 0 ends list
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    rsta <= 1'b0;
    cur_test = steps[0];
    for (int i = 0; i < n_steps; i++)
    begin
      if (steps[6*i] != cur_test)
      begin
        finish_test();
        cur_test = steps[6*i];
      end
      if (steps[6*i+1] == 2) drain();  // Sync point
      else
      begin
        idle_gap();
        send_req(steps[6*i+2], steps[6*i+1], steps[6*i+3], steps[6*i+4], steps[6*i+5]);
      end
    end
    finish_test();
    $display("Tests run %0d, errors %0d", tests_run, total_errs);
    if (total_errs == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog, reset plus clear plus a budget per step
  initial
  begin
    wait (loaded);
    repeat (10 + RAM_DEPTH + 40 * n_steps) @(posedge clk);
    $display("Timeout: the tests did not finish in %0d cycles", 10 + RAM_DEPTH + 40 * n_steps);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== uram_tdp.sv ====
/* UltraRAM style true-dual-port memory, no-change mode
   One-cycle array read, PIPE enable-qualified data stages and a reset output register */
`timescale 1ns/10ps

module uram_tdp #(
  parameter int AWIDTH = mem_pkg::ADDR_W,   // Address width
  parameter int DWIDTH = mem_pkg::DATA_W,   // Data width
  parameter int PIPE   = mem_pkg::NBPIPE    // Data pipe stages
) (
  input  logic              clk,
  input  logic              rsta,
  // Port A, read and write
  input  logic              i_en_a,
  input  logic              i_we_a,
  input  logic [AWIDTH-1:0] i_addr_a,
  input  logic [DWIDTH-1:0] i_din_a,
  output logic [DWIDTH-1:0] o_dout_a,
  // Port B, write only
  input  logic              i_en_b,
  input  logic              i_we_b,
  input  logic [AWIDTH-1:0] i_addr_b,
  input  logic [DWIDTH-1:0] i_din_b
);

  logic [DWIDTH-1:0] mem [0:(1 << AWIDTH)-1];  // Storage array

  logic [DWIDTH-1:0] mem_reg_a;        // Array read register
  logic [DWIDTH-1:0] pipe_a [PIPE];    // Data pipe
  logic [PIPE:0]     en_pipe_a;        // Enable pipe, one ahead of each data stage

  // Array writes from both ports
  // B is last so it wins a collision, which the assertion below flags anyway
  always_ff @(posedge clk)
  begin
    if (i_en_a && i_we_a)
    begin
      mem[i_addr_a] <= i_din_a;
    end
    if (i_en_b && i_we_b)
    begin
      mem[i_addr_b] <= i_din_b;
    end
  end

  // No-change read, a write keeps the old read data
  always_ff @(posedge clk)
  begin
    if (i_en_a && !i_we_a)
    begin
      mem_reg_a <= mem[i_addr_a];
    end
  end

  // Enable pipe advances every cycle
  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      en_pipe_a <= '0;
    end
    else
    begin
      en_pipe_a <= {en_pipe_a[PIPE-1:0], i_en_a};  // Shift in the port enable
    end
  end

  // Data stages, each loaded only when its enable arrives
  always_ff @(posedge clk)
  begin
    if (en_pipe_a[0])
    begin
      pipe_a[0] <= mem_reg_a;      // First stage from array register
    end
    for (int i = 1; i < PIPE; i++)
    begin
      if (en_pipe_a[i])
      begin
        pipe_a[i] <= pipe_a[i-1];
      end
    end
  end

  // Output register, cleared on reset
  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      o_dout_a <= '0;
    end
    else if (en_pipe_a[PIPE])
    begin
      o_dout_a <= pipe_a[PIPE-1];  // Valid PIPE+2 cycles after the read
    end
  end

  // Both ports writing one word in the same cycle
  a_no_write_collision : assert property (
    @(posedge clk) disable iff (rsta)
    !(i_en_a && i_we_a && i_en_b && i_we_b && (i_addr_a == i_addr_b))
  )
  else $error("uram_tdp: port A and B write the same address");

endmodule
